//--- verilog/fifo_pkg.sv
package fifo_pkg;

    // data path and register widths
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] count_t; // occupancy in words

    parameter byte_t VERSION = 8'd2;

    // register map
    parameter int REG_RST_VERSION  = 0; // write: soft reset, read: version
    parameter int REG_ALMOST_FULL  = 1;
    parameter int REG_ALMOST_EMPTY = 2;
    parameter int REG_READ_ERROR   = 3;
    parameter int REG_SIZE0        = 4; // read latches the byte size
    parameter int REG_SIZE1        = 5;
    parameter int REG_SIZE2        = 6;
    parameter int REG_SIZE3        = 7;

endpackage

//--- verilog/reg_bus_if.sv
`timescale 1ns/100ps

interface reg_bus_if #(
    parameter int ABUSWIDTH = 16
);

    logic [ABUSWIDTH-1:0] add;
    fifo_pkg::byte_t      data_in;  // host to core
    logic                 rd;
    logic                 wr;
    fifo_pkg::byte_t      data_out; // core to host

    modport core (
        input  add, data_in, rd, wr,
        output data_out
    );

    modport host (
        output add, data_in, rd, wr,
        input  data_out
    );

endinterface

//--- verilog/generic_fifo.sv
`timescale 1ns/100ps

module generic_fifo #(
    parameter int DATA_SIZE = 32,
    parameter int DEPTH     = 8
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic                 write,
    input  logic                 read,
    input  logic [DATA_SIZE-1:0] data_in,
    output logic                 full,
    output logic                 empty,
    output logic [DATA_SIZE-1:0] data_out,
    output fifo_pkg::count_t     size
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

    logic [DATA_SIZE-1:0] mem [DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic                 do_write;
    logic                 do_read;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        // wraps also for depths that are not a power of two
        if (ptr == PTR_LAST)
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full  = (size == fifo_pkg::count_t'(DEPTH));
    assign empty = (size == '0);

    // overflow and underflow are dropped here
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    // first word fall through, head always visible
    assign data_out = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_write)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_read)
                rd_ptr <= next_ptr(rd_ptr);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            size <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   size <= size + 1'b1;
                2'b01:   size <= size - 1'b1;
                default: size <= size; // idle or read and write together
            endcase
        end
    end

    // count must stay within the buffer over any sequence of pushes and pops
    a_size_bound: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        size <= fifo_pkg::count_t'(DEPTH)
    ) else $error("fifo size %0d exceeds depth %0d", size, DEPTH);

endmodule

//--- verilog/bram_fifo_core.sv
`timescale 1ns/100ps

module bram_fifo_core #(
    parameter int DEPTH            = 64,
    parameter int ALMOST_FULL_PCT  = 95,
    parameter int ALMOST_EMPTY_PCT = 5,
    parameter int ABUSWIDTH        = 16
) (
    input  logic              BUS_CLK,
    input  logic              RST,
    reg_bus_if.core           bus,

    input  logic              data_rd,
    input  logic              data_wr,
    input  fifo_pkg::word_t   data_in,
    output fifo_pkg::word_t   data_out,

    output logic              read_next,
    input  logic              src_empty,
    input  fifo_pkg::word_t   src_data,

    output logic              fifo_not_empty,
    output logic              fifo_full,
    output logic              fifo_near_full,
    output logic              fifo_read_error
);

    localparam fifo_pkg::byte_t AF_INIT = fifo_pkg::byte_t'(255 * ALMOST_FULL_PCT / 100);
    localparam fifo_pkg::byte_t AE_INIT = fifo_pkg::byte_t'(255 * ALMOST_EMPTY_PCT / 100);

    logic [ABUSWIDTH-1:0] add;
    logic                 soft_rst;
    logic                 rst_int;

    fifo_pkg::byte_t  af_value;
    fifo_pkg::byte_t  ae_value;
    fifo_pkg::byte_t  read_err;
    fifo_pkg::count_t count;
    fifo_pkg::count_t size_byte;
    fifo_pkg::count_t size_byte_latch;
    fifo_pkg::count_t af_level;
    fifo_pkg::count_t ae_level;

    logic            storage_write;
    logic            storage_full;
    logic            storage_empty;
    fifo_pkg::word_t storage_data;
    fifo_pkg::word_t storage_head;

    assign add = bus.add;

    // any write to address 0 resets the whole core
    assign soft_rst = bus.wr && (add == ABUSWIDTH'(fifo_pkg::REG_RST_VERSION));
    assign rst_int  = RST || soft_rst;

    // threshold registers
    always_ff @(posedge BUS_CLK) begin
        if (rst_int) begin
            af_value <= AF_INIT;
            ae_value <= AE_INIT;
        end else if (bus.wr) begin
            if (add == ABUSWIDTH'(fifo_pkg::REG_ALMOST_FULL))
                af_value <= bus.data_in;
            if (add == ABUSWIDTH'(fifo_pkg::REG_ALMOST_EMPTY))
                ae_value <= bus.data_in;
        end
    end

    assign size_byte = count << 2; // words to bytes

    // upper size bytes come from the copy taken by the address 4 read
    always_ff @(posedge BUS_CLK) begin
        if (bus.rd && add == ABUSWIDTH'(fifo_pkg::REG_SIZE0))
            size_byte_latch <= size_byte;
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus.rd) begin
            if (add == ABUSWIDTH'(fifo_pkg::REG_RST_VERSION))
                bus.data_out <= fifo_pkg::VERSION;
            else if (add == ABUSWIDTH'(fifo_pkg::REG_ALMOST_FULL))
                bus.data_out <= af_value;
            else if (add == ABUSWIDTH'(fifo_pkg::REG_ALMOST_EMPTY))
                bus.data_out <= ae_value;
            else if (add == ABUSWIDTH'(fifo_pkg::REG_READ_ERROR))
                bus.data_out <= read_err;
            else if (add == ABUSWIDTH'(fifo_pkg::REG_SIZE0))
                bus.data_out <= size_byte[7:0]; // live value at the latching edge
            else if (add == ABUSWIDTH'(fifo_pkg::REG_SIZE1))
                bus.data_out <= size_byte_latch[15:8];
            else if (add == ABUSWIDTH'(fifo_pkg::REG_SIZE2))
                bus.data_out <= size_byte_latch[23:16];
            else if (add == ABUSWIDTH'(fifo_pkg::REG_SIZE3))
                bus.data_out <= size_byte_latch[31:24];
            else
                bus.data_out <= '0;
        end
    end

    // drain the source only when no loopback word competes for the write port
    assign read_next     = !storage_full && !data_wr;
    assign storage_write = data_wr || (read_next && !src_empty);
    assign storage_data  = data_wr ? data_in : src_data;

    generic_fifo #(
        .DATA_SIZE (32),
        .DEPTH     (DEPTH)
    ) i_storage (
        .BUS_CLK  (BUS_CLK),
        .RST      (rst_int),
        .write    (storage_write),
        .read     (data_rd),
        .data_in  (storage_data),
        .full     (storage_full),
        .empty    (storage_empty),
        .data_out (storage_head),
        .size     (count)
    );

    // head word captured with the pop
    always_ff @(posedge BUS_CLK) begin
        if (data_rd)
            data_out <= storage_head;
    end

    assign fifo_not_empty  = !storage_empty;
    assign fifo_full       = storage_full;
    assign fifo_read_error = (read_err != '0);

    // saturating count of pops on empty storage
    always_ff @(posedge BUS_CLK) begin
        if (rst_int)
            read_err <= '0;
        else if (data_rd && storage_empty && read_err != 8'hff)
            read_err <= read_err + 1'b1;
    end

    // thresholds scaled from 1/256 steps to words
    assign af_level = ((fifo_pkg::count_t'(af_value) + 1'b1) *
                       fifo_pkg::count_t'(DEPTH)) >> 8;
    assign ae_level = ((fifo_pkg::count_t'(ae_value) + 1'b1) *
                       fifo_pkg::count_t'(DEPTH)) >> 8;

    // hysteresis between the two levels
    always_ff @(posedge BUS_CLK) begin
        if (rst_int)
            fifo_near_full <= 1'b0;
        else if (count >= af_level || af_value == '0)
            fifo_near_full <= 1'b1;
        else if ((count <= ae_level && ae_value != '0) || count == '0)
            fifo_near_full <= 1'b0;
    end

    // the source link must not be popped into a full storage FIFO
    a_no_drain_when_full: assert property (
        @(posedge BUS_CLK) disable iff (rst_int)
        !(read_next && fifo_full)
    ) else $error("read_next high while storage is full");

    // a reset on the same edge still clears a saturated count
    a_err_saturates: assert property (
        @(posedge BUS_CLK) disable iff (rst_int)
        (read_err == 8'hff && !rst_int) |=> (read_err == 8'hff)
    ) else $error("read error count wrapped");

endmodule

//--- verilog/bram_fifo.sv
`timescale 1ns/100ps

module bram_fifo #(
    parameter int DEPTH            = 64,
    parameter int SRC_DEPTH        = 8,
    parameter int ALMOST_FULL_PCT  = 95,
    parameter int ALMOST_EMPTY_PCT = 5,
    parameter int ABUSWIDTH        = 16
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,

    input  logic [ABUSWIDTH-1:0] bus_add,
    input  fifo_pkg::byte_t      bus_data_in,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    output fifo_pkg::byte_t      bus_data_out,

    input  logic                 data_rd,
    input  logic                 data_wr,
    input  fifo_pkg::word_t      data_in,
    output fifo_pkg::word_t      data_out,

    input  logic                 src_write,
    input  fifo_pkg::word_t      src_data,
    output logic                 src_full,

    output logic                 fifo_not_empty,
    output logic                 fifo_full,
    output logic                 fifo_near_full,
    output logic                 fifo_read_error
);

    logic            read_next;
    logic            src_empty;
    logic            src_rst;
    fifo_pkg::word_t src_word;

    reg_bus_if #(.ABUSWIDTH(ABUSWIDTH)) bus ();

    assign bus.add      = bus_add;
    assign bus.data_in  = bus_data_in;
    assign bus.rd       = bus_rd;
    assign bus.wr       = bus_wr;
    assign bus_data_out = bus.data_out;

    // soft reset clears the source FIFO as well
    assign src_rst = RST || (bus_wr && bus_add == ABUSWIDTH'(fifo_pkg::REG_RST_VERSION));

    generic_fifo #(
        .DATA_SIZE (32),
        .DEPTH     (SRC_DEPTH)
    ) i_src_fifo (
        .BUS_CLK  (BUS_CLK),
        .RST      (src_rst),
        .write    (src_write),
        .read     (read_next),
        .data_in  (src_data),
        .full     (src_full),
        .empty    (src_empty),
        .data_out (src_word),
        .size     ()
    );

    bram_fifo_core #(
        .DEPTH            (DEPTH),
        .ALMOST_FULL_PCT  (ALMOST_FULL_PCT),
        .ALMOST_EMPTY_PCT (ALMOST_EMPTY_PCT),
        .ABUSWIDTH        (ABUSWIDTH)
    ) i_core (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .bus             (bus.core),
        .data_rd         (data_rd),
        .data_wr         (data_wr),
        .data_in         (data_in),
        .data_out        (data_out),
        .read_next       (read_next),
        .src_empty       (src_empty),
        .src_data        (src_word),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_full       (fifo_full),
        .fifo_near_full  (fifo_near_full),
        .fifo_read_error (fifo_read_error)
    );

endmodule

//--- bench/tb_bram_fifo.sv
`timescale 1ns/100ps

module tb_bram_fifo;

    logic            BUS_CLK;
    logic            RST;
    logic [15:0]     bus_add;
    fifo_pkg::byte_t bus_data_in;
    logic            bus_rd;
    logic            bus_wr;
    fifo_pkg::byte_t bus_data_out;
    logic            data_rd;
    logic            data_wr;
    fifo_pkg::word_t data_in;
    fifo_pkg::word_t data_out;
    logic            src_write;
    fifo_pkg::word_t src_data;
    logic            src_full;
    logic            fifo_not_empty;
    logic            fifo_full;
    logic            fifo_near_full;
    logic            fifo_read_error;

    fifo_pkg::word_t model[$]; // expected storage order, source FIFO included
    int seed;
    int checks;
    int errors;
    int timeouts;
    int dropped;
    int cases;

    bram_fifo #(
        .DEPTH            (64),
        .SRC_DEPTH        (8),
        .ALMOST_FULL_PCT  (95),
        .ALMOST_EMPTY_PCT (5),
        .ABUSWIDTH        (16)
    ) uut (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .bus_add         (bus_add),
        .bus_data_in     (bus_data_in),
        .bus_rd          (bus_rd),
        .bus_wr          (bus_wr),
        .bus_data_out    (bus_data_out),
        .data_rd         (data_rd),
        .data_wr         (data_wr),
        .data_in         (data_in),
        .data_out        (data_out),
        .src_write       (src_write),
        .src_data        (src_data),
        .src_full        (src_full),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_full       (fifo_full),
        .fifo_near_full  (fifo_near_full),
        .fifo_read_error (fifo_read_error)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #20 BUS_CLK = ~BUS_CLK;
    end

    task automatic write_reg(input int addr, input int value);
        @(posedge BUS_CLK);
        bus_add     <= 16'(addr);
        bus_data_in <= 8'(value);
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
        if (addr == fifo_pkg::REG_RST_VERSION)
            model.delete(); // soft reset clears both FIFOs
    endtask

    task automatic read_reg(input int addr, input int expected);
        @(posedge BUS_CLK);
        bus_add <= 16'(addr);
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        checks++;
        assert (bus_data_out == 8'(expected)) else begin
            errors++;
            $display("** Error at %0t: register %0d read %0d, expected %0d",
                     $time, addr, bus_data_out, expected);
        end
    endtask

    task automatic wait_not_empty();
        int cycles;
        cycles = 0;
        @(negedge BUS_CLK);
        while (!fifo_not_empty && cycles < 20) begin
            @(negedge BUS_CLK);
            cycles++;
        end
        if (!fifo_not_empty) begin
            timeouts++;
            $display("timeout: fifo_not_empty stayed low for 20 cycles after a push");
        end
    endtask

    task automatic push_source(input int n);
        fifo_pkg::word_t word;
        for (int i = 0; i < n; i++) begin
            word = $random(seed);
            @(posedge BUS_CLK);
            src_write <= 1'b1;
            src_data  <= word;
            @(negedge BUS_CLK);
            if (!src_full)
                model.push_back(word);
            else
                dropped++; // push lost on a full source FIFO
        end
        @(posedge BUS_CLK);
        src_write <= 1'b0;
        @(posedge BUS_CLK); // last word moves into storage here
        if (model.size() != 0)
            wait_not_empty();
    endtask

    task automatic push_loopback(input int n);
        fifo_pkg::word_t word;
        for (int i = 0; i < n; i++) begin
            word = $random(seed);
            @(posedge BUS_CLK);
            data_wr <= 1'b1;
            data_in <= word;
            model.push_back(word);
        end
        @(posedge BUS_CLK);
        data_wr <= 1'b0;
    endtask

    task automatic pop_words(input int n);
        fifo_pkg::word_t expected;
        for (int i = 0; i < n; i++) begin
            if (model.size() == 0) begin
                errors++;
                $display("case file asks for a pop but the model queue is empty");
                return;
            end
            expected = model.pop_front();
            @(posedge BUS_CLK);
            data_rd <= 1'b1;
            @(posedge BUS_CLK);
            data_rd <= 1'b0;
            @(negedge BUS_CLK);
            checks++;
            assert (data_out == expected) else begin
                errors++;
                $display("** Error at %0t: popped %h, expected %h", $time, data_out, expected);
            end
        end
        checks++;
        assert (fifo_not_empty == (model.size() != 0)) else begin
            errors++;
            $display("** Error at %0t: fifo_not_empty %b with %0d words in the model",
                     $time, fifo_not_empty, model.size());
        end
    endtask

    task automatic pop_while_empty(input int n);
        if (model.size() != 0) begin
            errors++;
            $display("empty pops requested while the model still holds words");
        end
        for (int i = 0; i < n; i++) begin
            @(posedge BUS_CLK);
            data_rd <= 1'b1;
            @(posedge BUS_CLK);
            data_rd <= 1'b0;
        end
    endtask

    task automatic check_flag(input int code, input int expected);
        logic value;
        repeat (2) @(posedge BUS_CLK); // near-full lags the count by one edge
        @(negedge BUS_CLK);
        case (code)
            0:       value = fifo_not_empty;
            1:       value = fifo_full;
            2:       value = fifo_near_full;
            3:       value = fifo_read_error;
            4:       value = src_full;
            default: value = 1'bx;
        endcase
        checks++;
        assert (value === 1'(expected)) else begin
            errors++;
            $display("** Error at %0t: flag %0d is %b, expected %0d", $time, code, value, expected);
        end
    endtask

    task automatic run_case(input logic [7:0] op, input int a, input int b);
        cases++;
        case (op)
            "W":     write_reg(a, b);
            "R":     read_reg(a, b);
            "P":     push_source(a);
            "L":     push_loopback(a);
            "D":     pop_words(a);
            "E":     pop_while_empty(a);
            "F":     check_flag(a, b);
            default: begin
                errors++;
                $display("unknown operation %c in the case file", op);
            end
        endcase
    endtask

    initial begin
        string line;
        logic [7:0] op;
        int fd;
        int n;
        int a;
        int b;
        seed = 32'h93f8;
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        data_rd = 1'b0;
        data_wr = 1'b0;
        data_in = '0;
        src_write = 1'b0;
        src_data = '0;
        repeat (5) @(posedge BUS_CLK);
        RST <= 1'b0;
        fd = $fopen("bench/fifo_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bench/fifo_cases.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    a = 0;
                    b = 0;
                    n = $sscanf(line, "%c %d %d", op, a, b);
                    run_case(op, a, b);
                end
            end
            $fclose(fd);
        end
        $display("cases %0d  checks %0d  errors %0d  timeouts %0d  dropped pushes %0d",
                 cases, checks, errors, timeouts, dropped);
        if (errors == 0 && timeouts == 0 && cases > 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- bench/fifo_cases.txt
# op a b: W addr value, R addr expected, P/L/D/E word count, F flag expected
# flag codes: 0 fifo_not_empty, 1 fifo_full, 2 fifo_near_full, 3 fifo_read_error, 4 src_full
R 0 2
R 1 242
R 2 12
W 1 200
W 2 30
R 1 200
R 2 30
P 3
L 2
P 2
D 7
F 0 0
P 40
R 4 160
R 5 0
R 6 0
R 7 0
W 0 0
R 1 242
R 2 12
E 3
R 3 3
F 3 1
E 300
R 3 255
W 0 0
W 1 127
W 2 63
L 31
F 2 0
L 1
F 2 1
D 15
F 2 1
D 1
F 2 0
D 16
P 80
F 1 1
F 4 1
D 72
F 0 0
F 4 0

//--- all.f
verilog/fifo_pkg.sv
verilog/reg_bus_if.sv
verilog/generic_fifo.sv
verilog/bram_fifo_core.sv
verilog/bram_fifo.sv
bench/tb_bram_fifo.sv

//--- run.sh
#!/bin/sh
# build and run the bram_fifo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_bram_fifo -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
